//--- Makefile
# Verilator build and run of the PPU background pixel path
# Any variable can be set on the command line, e.g. make sim TOP=ppu_bg_tb

VERILATOR ?= verilator
TOP       ?= ppu_bg_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/bg_fetcher.sv
`default_nettype none

`include "ppu_params.svh"

module bg_fetcher (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire logic                      flush,
  input  wire ppu_timing_pkg::ppu_mode_t mode,
  input  wire logic                [7:0] ly,
  input  wire logic                [8:0] dot,
  input  wire logic                [7:0] lcdc,
  input  wire logic                [7:0] scx,
  input  wire logic                [7:0] scy,
  input  wire logic                [7:0] wy,
  input  wire logic                [7:0] wx,
  output logic                    [15:0] vram_addr,
  output logic                           vram_read,
  input  wire logic                [7:0] vram_rdata,
  input  wire logic                      fifo_empty,
  output logic                           push,
  output ppu_pixel_pkg::color_t          push_row [8]
);

  ppu_pixel_pkg::fetch_state_t state;
  ppu_pixel_pkg::fetch_phase_t phase;
  ppu_pixel_pkg::fetch_state_t next_state;

  // Tile column being fetched, advances on each push
  logic [4:0] fetch_x;

  // Window row counter, separate from LY
  logic [7:0] window_line;
  // Set once a window tile went out on this line
  logic       win_drawn;

  // Fetched tile index and bitplanes
  logic [7:0] tile_index;
  logic [7:0] tile_low;
  logic [7:0] tile_high;

  // Window left edge WX-7, may go negative
  wire signed [8:0] s_win_x = $signed({1'b0, wx}) - 9'sd7;
  // Clamped to 0
  wire [7:0] window_x_start = s_win_x[8] ? 8'd0 : s_win_x[7:0];
  // First window tile column, rounded up
  wire [7:0] win_start_round = window_x_start + 8'd7;
  wire [4:0] window_start_tile = win_start_round[7:3];

  wire window_visible = lcdc[5] && (ly >= wy) &&
                        (s_win_x < $signed({1'b0, `PPU_SCREEN_WIDTH}));
  wire window_active = window_visible && ({fetch_x, 3'b000} >= window_x_start);

  // Map base and position inside the 32x32 map
  wire [15:0] bg_map_base  = lcdc[3] ? `PPU_MAP_HIGH : `PPU_MAP_LOW;
  wire [15:0] win_map_base = lcdc[6] ? `PPU_MAP_HIGH : `PPU_MAP_LOW;
  wire [15:0] map_base     = window_active ? win_map_base : bg_map_base;

  // Column wraps mod 32 through the 5-bit width
  wire [4:0] map_x = window_active ? (fetch_x - window_start_tile) : (scx[7:3] + fetch_x);
  wire [7:0] map_y = window_active ? window_line : (scy + ly);
  wire [2:0] tile_y = map_y[2:0];

  wire [15:0] tilemap_addr = map_base + {6'b0, map_y[7:3], 5'b0} + {11'b0, map_x};

  // Row address of the low byte, high byte is at +1
  function automatic logic [15:0] tile_row_addr_fn(input logic       unsigned_mode,
                                                   input logic [7:0] tid,
                                                   input logic [2:0] row);
    logic [15:0] base;
    logic [15:0] offset;
    if (unsigned_mode) begin
      base   = `PPU_TILES_UNSIGNED;
      offset = {4'b0, tid, 4'b0};
    end else begin
      // Sign extend so 128..255 land below 0x9000
      base   = `PPU_TILES_SIGNED;
      offset = {{4{tid[7]}}, tid, 4'b0};
    end
    tile_row_addr_fn = base + offset + {12'b0, row, 1'b0};
  endfunction

  wire [15:0] tile_row_addr = tile_row_addr_fn(lcdc[4], tile_index, tile_y);

  // Fetch runs only in drawing, flush dot excluded
  wire fetch_active = (mode == ppu_timing_pkg::PPU_MODE_3) && !flush;
  wire capture      = fetch_active && (phase == ppu_pixel_pkg::PHASE_1);

  assign vram_read = fetch_active && (phase == ppu_pixel_pkg::PHASE_0) &&
                     (state != ppu_pixel_pkg::FETCH_PUSH);

  always_comb begin
    case (state)
      ppu_pixel_pkg::FETCH_LOW:  vram_addr = tile_row_addr;
      ppu_pixel_pkg::FETCH_HIGH: vram_addr = tile_row_addr + 16'd1;
      default:                   vram_addr = tilemap_addr;
    endcase
  end

  always_comb begin
    case (state)
      ppu_pixel_pkg::FETCH_TILE: next_state = ppu_pixel_pkg::FETCH_LOW;
      ppu_pixel_pkg::FETCH_LOW:  next_state = ppu_pixel_pkg::FETCH_HIGH;
      default:                   next_state = ppu_pixel_pkg::FETCH_PUSH;
    endcase
  end

  // Leftmost pixel from bit 7 of both planes
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      push_row[i] = {tile_high[7-i], tile_low[7-i]};
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= ppu_pixel_pkg::FETCH_TILE;
      phase       <= ppu_pixel_pkg::PHASE_0;
      fetch_x     <= 5'd0;
      push        <= 1'b0;
      window_line <= 8'd0;
      win_drawn   <= 1'b0;
    end else begin
      push <= 1'b0;

      // Window row restarts each frame, steps after each line that drew it
      if (ly == 8'd0 && dot == 9'd0) begin
        window_line <= 8'd0;
        win_drawn   <= 1'b0;
      end else if (mode == ppu_timing_pkg::PPU_MODE_0 && win_drawn) begin
        window_line <= window_line + 8'd1;
        win_drawn   <= 1'b0;
      end

      if (flush) begin
        // New line of drawing
        state   <= ppu_pixel_pkg::FETCH_TILE;
        phase   <= ppu_pixel_pkg::PHASE_0;
        fetch_x <= 5'd0;
      end else if (mode == ppu_timing_pkg::PPU_MODE_3) begin
        if (state == ppu_pixel_pkg::FETCH_PUSH) begin
          // Hold until the FIFO has drained
          if (fifo_empty) begin
            push    <= 1'b1;
            fetch_x <= fetch_x + 5'd1;
            state   <= ppu_pixel_pkg::FETCH_TILE;
            if (window_active) begin
              win_drawn <= 1'b1;
            end
          end
        end else if (phase == ppu_pixel_pkg::PHASE_0) begin
          phase <= ppu_pixel_pkg::PHASE_1;
        end else begin
          phase <= ppu_pixel_pkg::PHASE_0;
          state <= next_state;
        end
      end
    end
  end

  // VRAM reply lands in phase 1
  always_ff @(posedge clk) begin
    if (capture) begin
      case (state)
        ppu_pixel_pkg::FETCH_TILE: tile_index <= vram_rdata;
        ppu_pixel_pkg::FETCH_LOW:  tile_low   <= vram_rdata;
        ppu_pixel_pkg::FETCH_HIGH: tile_high  <= vram_rdata;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/bg_pixel_fifo.sv
`default_nettype none

module bg_pixel_fifo (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire logic                      flush,
  input  wire ppu_timing_pkg::ppu_mode_t mode,
  input  wire logic                [7:0] scx,
  input  wire logic                      push,
  input  wire ppu_pixel_pkg::color_t     push_row [8],
  output logic                           fifo_empty,
  output logic                           pixel_valid,
  output ppu_pixel_pkg::color_t          pixel_color
);

  // Entry 0 is the next pixel out
  ppu_pixel_pkg::color_t fifo_q [8];

  // Pixels held, 0 to 8
  logic [3:0] count;
  // Fine scroll pixels still to drop
  logic [2:0] discard;

  // One pixel leaves per drawing dot
  wire shifting = (mode == ppu_timing_pkg::PPU_MODE_3) && !flush && (count != 4'd0);

  assign fifo_empty  = (count == 4'd0);
  assign pixel_valid = shifting && (discard == 3'd0);
  assign pixel_color = fifo_q[0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count   <= 4'd0;
      discard <= 3'd0;
    end else if (flush) begin
      // Line start, drop leftovers and arm SCX mod 8
      count   <= 4'd0;
      discard <= scx[2:0];
    end else if (push) begin
      count <= 4'd8;
    end else if (shifting) begin
      count <= count - 4'd1;
      if (discard != 3'd0) begin
        discard <= discard - 3'd1;
      end
    end
  end

  // Row load or shift toward entry 0
  always_ff @(posedge clk) begin
    if (push) begin
      for (int i = 0; i < 8; i++) begin
        fifo_q[i] <= push_row[i];
      end
    end else if (shifting) begin
      for (int i = 0; i < 7; i++) begin
        fifo_q[i] <= fifo_q[i+1];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/ppu_bg_top.sv
`default_nettype none

module ppu_bg_top (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire logic                [7:0] lcdc,
  input  wire logic                [7:0] scx,
  input  wire logic                [7:0] scy,
  input  wire logic                [7:0] wy,
  input  wire logic                [7:0] wx,
  output logic                    [15:0] vram_addr,
  output logic                           vram_read,
  input  wire logic                [7:0] vram_rdata,
  output logic                           pixel_valid,
  output ppu_pixel_pkg::color_t          pixel_color,
  output logic                     [7:0] ly,
  output ppu_timing_pkg::ppu_mode_t      mode
);

  // Timer to fetcher and FIFO
  logic [8:0] dot;
  logic       flush;

  // Fetcher and FIFO handshake
  logic                  push;
  ppu_pixel_pkg::color_t push_row [8];
  logic                  fifo_empty;

  ppu_line_timer i_timer (
    .clk         (clk),
    .reset       (reset),
    .pixel_valid (pixel_valid),
    .mode        (mode),
    .ly          (ly),
    .dot         (dot),
    .flush       (flush)
  );

  bg_fetcher i_fetcher (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .mode       (mode),
    .ly         (ly),
    .dot        (dot),
    .lcdc       (lcdc),
    .scx        (scx),
    .scy        (scy),
    .wy         (wy),
    .wx         (wx),
    .vram_addr  (vram_addr),
    .vram_read  (vram_read),
    .vram_rdata (vram_rdata),
    .fifo_empty (fifo_empty),
    .push       (push),
    .push_row   (push_row)
  );

  // Pixel output also feeds the timer's count
  bg_pixel_fifo i_fifo (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .mode        (mode),
    .scx         (scx),
    .push        (push),
    .push_row    (push_row),
    .fifo_empty  (fifo_empty),
    .pixel_valid (pixel_valid),
    .pixel_color (pixel_color)
  );

endmodule

`default_nettype wire

//--- source/ppu_line_timer.sv
`default_nettype none

`include "ppu_params.svh"

module ppu_line_timer (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     pixel_valid,
  output ppu_timing_pkg::ppu_mode_t     mode,
  output logic                    [7:0] ly,
  output logic                    [8:0] dot,
  output logic                          flush
);

  // Pixels shipped so far in this mode 3
  logic [7:0] pix_count;

  wire [7:0] ly_next = ly + 8'd1;
  wire       line_end = (dot == `PPU_LINE_DOTS - 9'd1);
  wire       scan_end = (mode == ppu_timing_pkg::PPU_MODE_2) &&
                        (dot == `PPU_MODE2_DOTS - 9'd1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot       <= 9'd0;
      ly        <= 8'd0;
      mode      <= ppu_timing_pkg::PPU_MODE_2;
      flush     <= 1'b0;
      pix_count <= 8'd0;
    end else begin
      // Flush is a single-dot pulse
      flush <= 1'b0;

      if (line_end) begin
        dot <= 9'd0;
        if (ly == `PPU_TOTAL_LINES - 8'd1) begin
          // Frame wrap, back to OAM scan of line 0
          ly   <= 8'd0;
          mode <= ppu_timing_pkg::PPU_MODE_2;
        end else begin
          ly <= ly_next;
          // Visible lines start with OAM scan, the rest is vblank
          if (ly_next < `PPU_VISIBLE_LINES) begin
            mode <= ppu_timing_pkg::PPU_MODE_2;
          end else begin
            mode <= ppu_timing_pkg::PPU_MODE_1;
          end
        end
      end else begin
        dot <= dot + 9'd1;

        if (scan_end) begin
          // Drawing begins at dot 80 together with flush
          mode      <= ppu_timing_pkg::PPU_MODE_3;
          flush     <= 1'b1;
          pix_count <= 8'd0;
        end else if (mode == ppu_timing_pkg::PPU_MODE_3 && pixel_valid) begin
          // Last visible pixel ends drawing on the next clock
          if (pix_count == `PPU_SCREEN_WIDTH - 8'd1) begin
            mode <= ppu_timing_pkg::PPU_MODE_0;
          end
          pix_count <= pix_count + 8'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/ppu_params.svh
`ifndef PPU_PARAMS_SVH
`define PPU_PARAMS_SVH

// Screen size in pixels and lines
`define PPU_SCREEN_WIDTH    8'd160
`define PPU_VISIBLE_LINES   8'd144

// Lines per frame, vblank included
`define PPU_TOTAL_LINES     8'd154

// Dots per scanline
`define PPU_LINE_DOTS       9'd456

// OAM scan length at the start of each visible line
`define PPU_MODE2_DOTS      9'd80

// Tile map bases, picked by LCDC bit 3 or bit 6
`define PPU_MAP_LOW         16'h9800
`define PPU_MAP_HIGH        16'h9C00

// Tile data bases, picked by LCDC bit 4
`define PPU_TILES_UNSIGNED  16'h8000
`define PPU_TILES_SIGNED    16'h9000

`endif

//--- source/ppu_pixel_pkg.sv
`default_nettype none

package ppu_pixel_pkg;

  // 2-bit colour index, before any palette
  typedef logic [1:0] color_t;

  // Background fetcher steps for one tile
  typedef enum logic [1:0] {
    FETCH_TILE = 2'd0,  // Tile index from the map
    FETCH_LOW  = 2'd1,  // Low bitplane byte
    FETCH_HIGH = 2'd2,  // High bitplane byte
    FETCH_PUSH = 2'd3   // Wait for an empty FIFO
  } fetch_state_t;

  // Two dots per VRAM access
  typedef enum logic {
    PHASE_0 = 1'b0,  // Address and strobe out
    PHASE_1 = 1'b1   // Data back, capture
  } fetch_phase_t;

endpackage

`default_nettype wire

//--- source/ppu_timing_pkg.sv
`default_nettype none

package ppu_timing_pkg;

  // PPU modes, encoded as in the STAT register
  typedef enum logic [1:0] {
    PPU_MODE_0 = 2'd0,  // Horizontal blank
    PPU_MODE_1 = 2'd1,  // Vertical blank
    PPU_MODE_2 = 2'd2,  // OAM scan
    PPU_MODE_3 = 2'd3   // Drawing
  } ppu_mode_t;

endpackage

`default_nettype wire

//--- verification/ppu_bg_tb.sv
`default_nettype none

`include "ppu_params.svh"

module ppu_bg_tb;

  timeunit 1ns;
  timeprecision 100ps;

  // Geometry and VRAM map as plain integers
  localparam int line_dots      = `PPU_LINE_DOTS;
  localparam int total_lines    = `PPU_TOTAL_LINES;
  localparam int visible_lines  = `PPU_VISIBLE_LINES;
  localparam int mode2_dots     = `PPU_MODE2_DOTS;
  localparam int screen_width   = `PPU_SCREEN_WIDTH;
  localparam int map_low        = `PPU_MAP_LOW;
  localparam int map_high       = `PPU_MAP_HIGH;
  localparam int tiles_unsigned = `PPU_TILES_UNSIGNED;
  localparam int tiles_signed   = `PPU_TILES_SIGNED;
  // Five frames per test plus reset and some slack
  localparam int    num_tests   = 5;
  localparam longint frame_ns   = longint'(line_dots) * total_lines * 40;
  localparam longint watchdog_ns = num_tests * 5 * frame_ns + 16 * 40 + 100000;

  logic                      clk;
  logic                      reset;
  logic                [7:0] lcdc;
  logic                [7:0] scx;
  logic                [7:0] scy;
  logic                [7:0] wy;
  logic                [7:0] wx;
  logic               [15:0] vram_addr;
  logic                      vram_read;
  logic                [7:0] vram_rdata;
  logic                      pixel_valid;
  ppu_pixel_pkg::color_t     pixel_color;
  logic                [7:0] ly;
  ppu_timing_pkg::ppu_mode_t mode;

  // 0x8000 to 0x9FFF
  logic [7:0] vram_mem [0:8191];
  logic       read_seen;
  logic [15:0] read_addr;
  logic [15:0] lfsr_state;
  int          check_count;
  int          error_count;

  ppu_tb_clock i_clock (
    .clk   (clk),
    .reset (reset)
  );

  ppu_bg_top i_dut (
    .clk         (clk),
    .reset       (reset),
    .lcdc        (lcdc),
    .scx         (scx),
    .scy         (scy),
    .wy          (wy),
    .wx          (wx),
    .vram_addr   (vram_addr),
    .vram_read   (vram_read),
    .vram_rdata  (vram_rdata),
    .pixel_valid (pixel_valid),
    .pixel_color (pixel_color),
    .ly          (ly),
    .mode        (mode)
  );

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Fail at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Galois LFSR of 16 bits with bit 0 as the output bit
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // New random VRAM image with one LFSR step per bit
  task automatic fill_vram();
    logic [7:0] b;
    for (int a = 0; a < 8192; a++) begin
      for (int k = 0; k < 8; k++) begin
        b = {b[6:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
      end
      vram_mem[a] = b;
    end
  endtask

  function automatic logic [7:0] vram_byte(input int addr);
    return vram_mem[13'(addr - tiles_unsigned)];
  endfunction

  // VRAM model with data valid for the whole clock after the strobe
  always begin
    @(negedge clk);
    read_seen = vram_read;
    read_addr = vram_addr;
    @(posedge clk);
    #2;
    if (read_seen) begin
      check_value("VRAM read outside 0x8000-0x9FFF", read_addr[15:13], 3'b100);
      vram_rdata = vram_mem[read_addr[12:0]];
    end
  end

  // Expected colour index at screen x on a line from the map and tile rules
  function automatic ppu_pixel_pkg::color_t expected_pixel(input int x, input int line_no,
                                                           input int win_row, input logic win_on);
    int px;
    int py;
    int map_base;
    int tile_id;
    int row_addr;
    int bit_pos;
    logic [7:0] tile;
    logic [7:0] lo;
    logic [7:0] hi;
    if (win_on && x >= int'(wx) - 7) begin
      // Window space starts at its left edge and its own row counter
      px       = x - (int'(wx) - 7);
      py       = win_row;
      map_base = lcdc[6] ? map_high : map_low;
    end else begin
      // Background wraps at 256 both ways
      px       = (x + int'(scx)) % 256;
      py       = (line_no + int'(scy)) % 256;
      map_base = lcdc[3] ? map_high : map_low;
    end
    tile = vram_byte(map_base + (py / 8) * 32 + px / 8);
    if (lcdc[4]) begin
      tile_id  = int'(tile);
      row_addr = tiles_unsigned + tile_id * 16 + (py % 8) * 2;
    end else begin
      tile_id  = int'($signed(tile));
      row_addr = tiles_signed + tile_id * 16 + (py % 8) * 2;
    end
    lo = vram_byte(row_addr);
    hi = vram_byte(row_addr + 1);
    // Bit 7 is the leftmost pixel
    bit_pos = 7 - (px % 8);
    return {hi[bit_pos], lo[bit_pos]};
  endfunction

  task automatic drive_regs(input logic [7:0] lcdc_v, scx_v, scy_v, wy_v, wx_v);
    @(posedge clk);
    #2;
    lcdc = lcdc_v;
    scx  = scx_v;
    scy  = scy_v;
    wy   = wy_v;
    wx   = wx_v;
  endtask

  // Returns at the first negedge of dot 0 on line 0
  task automatic wait_frame_start();
    @(negedge clk);
    while (ly != 8'(total_lines - 1)) begin
      @(negedge clk);
    end
    while (ly != 8'd0) begin
      @(negedge clk);
    end
  endtask

  // One full frame with every dot checked for LY, mode and pixels
  task automatic check_frame();
    int line_pix;
    int win_row;
    logic win_on;
    ppu_timing_pkg::ppu_mode_t exp_mode;
    wait_frame_start();
    win_row = 0;
    for (int line_no = 0; line_no < total_lines; line_no++) begin
      line_pix = 0;
      win_on   = lcdc[5] && line_no >= int'(wy) && int'(wx) - 7 < screen_width;
      for (int d = 0; d < line_dots; d++) begin
        if (line_no != 0 || d != 0) begin
          @(negedge clk);
        end
        // Drawing lasts until the dot after the 160th pixel
        if (line_no >= visible_lines) begin
          exp_mode = ppu_timing_pkg::PPU_MODE_1;
        end else if (d < mode2_dots) begin
          exp_mode = ppu_timing_pkg::PPU_MODE_2;
        end else if (line_pix < screen_width) begin
          exp_mode = ppu_timing_pkg::PPU_MODE_3;
        end else begin
          exp_mode = ppu_timing_pkg::PPU_MODE_0;
        end
        check_value("ly", ly, line_no);
        check_value($sformatf("mode at line %0d dot %0d", line_no, d), mode, exp_mode);
        if (pixel_valid) begin
          check_value("mode during pixel_valid", mode, ppu_timing_pkg::PPU_MODE_3);
          if (line_pix < screen_width) begin
            check_value($sformatf("pixel %0d of line %0d", line_pix, line_no), pixel_color,
                        expected_pixel(line_pix, line_no, win_row, win_on));
          end
          line_pix++;
        end
      end
      check_value($sformatf("pixels on line %0d", line_no), line_pix,
                  line_no < visible_lines ? screen_width : 0);
      if (win_on) begin
        win_row++;
      end
    end
    // LY wraps into the next frame
    @(negedge clk);
    check_value("ly after wrap", ly, 0);
    check_value("mode after wrap", mode, ppu_timing_pkg::PPU_MODE_2);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s finished, %0d mismatches", name, error_count - errs_before);
  endtask

  task automatic bg_unsigned_frame();
    int errs_before;
    errs_before = error_count;
    fill_vram();
    drive_regs(8'h91, 8'h00, 8'h00, 8'h00, 8'h00);
    check_frame();
    report_test("background with unsigned tiles", errs_before);
  endtask

  // Fine SCX of 3 with both axes wrapping around the map
  task automatic scrolled_frame();
    int errs_before;
    errs_before = error_count;
    fill_vram();
    drive_regs(8'h91, 8'hA3, 8'hC7, 8'h00, 8'h00);
    check_frame();
    report_test("scrolled background", errs_before);
  endtask

  task automatic signed_high_map_frame();
    int errs_before;
    errs_before = error_count;
    fill_vram();
    drive_regs(8'h89, 8'h14, 8'h30, 8'h00, 8'h00);
    check_frame();
    report_test("signed tiles from the high map", errs_before);
  endtask

  // Window at x 40 from line 33 and then parked below the screen
  task automatic window_frame();
    int errs_before;
    errs_before = error_count;
    fill_vram();
    drive_regs(8'hF1, 8'h18, 8'h0A, 8'd33, 8'd47);
    check_frame();
    drive_regs(8'hF1, 8'h18, 8'h0A, 8'd150, 8'd47);
    check_frame();
    report_test("window", errs_before);
  endtask

  // Longest discard gives the longest drawing time
  task automatic frame_timing();
    int errs_before;
    errs_before = error_count;
    fill_vram();
    drive_regs(8'h91, 8'h07, 8'h55, 8'h00, 8'h00);
    check_frame();
    report_test("frame timing", errs_before);
  endtask

  initial begin
    lcdc        = 8'h00;
    scx         = 8'h00;
    scy         = 8'h00;
    wy          = 8'h00;
    wx          = 8'h00;
    vram_rdata  = 8'h00;
    lfsr_state  = 16'd7;
    check_count = 0;
    error_count = 0;
    wait (reset === 1'b0);
    bg_unsigned_frame();
    scrolled_frame();
    signed_high_map_frame();
    window_frame();
    frame_timing();
    $display("Summary: %0d checks, %0d mismatches", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Ends a run that stopped making progress
  initial begin
    #(watchdog_ns);
    $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/ppu_tb_clock.sv
`default_nettype none

module ppu_tb_clock (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset held for 16 rising edges, released just after the last one
  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
source/ppu_timing_pkg.sv
source/ppu_pixel_pkg.sv
source/ppu_line_timer.sv
source/bg_fetcher.sv
source/bg_pixel_fifo.sv
source/ppu_bg_top.sv
verification/ppu_tb_clock.sv
verification/ppu_bg_tb.sv
